// File: build.f
+incdir+hdl
+incdir+testbench
hdl/isa_pkg.sv
hdl/dispatch_pkg.sv
hdl/fetch_stage.sv
hdl/operand_extract.sv
hdl/dispatch_stage.sv
hdl/dispatch_top.sv
testbench/tb_dispatch.sv

// File: hdl/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// Instruction word width
`define INSN_BITS 32
// Register and PC width
`define GPR_BITS 64
// Register index width
`define GPR_IDX_BITS 5
// Immediate width after extension
`define IMM_BITS 64

// Fixed register numbers
`define LINK_REG 30
`define ZERO_REG 31

`endif

// File: hdl/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

  // How the register file side treats a register field
  typedef enum logic [1:0] {
    REG_IS_UNUSED,
    REG_IS_USED,
    REG_IS_STUR
  } reg_status_t;

  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  // Operation requested from the functional unit
  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_OR,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_MOV,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_B_COND,
    FU_OP_PASS_A
  } fu_op_t;

  typedef struct packed {
    isa_pkg::insn_t insn;
    isa_pkg::gpr_t pc;
  } fetch_pkt_t;

  typedef struct packed {
    isa_pkg::gpr_idx_t src1;
    reg_status_t src1_status;
    isa_pkg::gpr_idx_t src2;
    reg_status_t src2_status;
    isa_pkg::gpr_idx_t dst;
    reg_status_t dst_status;
    isa_pkg::imm_t imm;
    logic imm_signed;
    isa_pkg::cond_t cond;
  } operands_t;

  typedef struct packed {
    fu_t fu_id;
    fu_op_t fu_op;
    logic set_nzcv;
    logic use_imm;
    logic uses_nzcv;
    logic mispredict;
  } ctl_t;

  // Bundle handed to the register file side
  typedef struct packed {
    isa_pkg::gpr_t pc;
    operands_t operands;
    ctl_t ctl;
  } decoded_t;

endpackage

`default_nettype wire

// File: hdl/dispatch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_stage (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    valid,
  input  isa_pkg::opcode_t        opcode,
  input  isa_pkg::gpr_t           pc,
  input  dispatch_pkg::operands_t operands,
  output logic                    done,
  output dispatch_pkg::decoded_t  decoded
);

  dispatch_pkg::ctl_t ctl;

  always_comb begin
    // Only the unscaled loads and stores go to the load/store unit
    if (opcode == isa_pkg::OP_LDUR || opcode == isa_pkg::OP_STUR) begin
      ctl.fu_id = dispatch_pkg::FU_LS;
    end else begin
      ctl.fu_id = dispatch_pkg::FU_ALU;
    end

    case (opcode)
      isa_pkg::OP_ADD, isa_pkg::OP_ADDS: ctl.fu_op = dispatch_pkg::FU_OP_PLUS;
      isa_pkg::OP_SUB, isa_pkg::OP_SUBS: ctl.fu_op = dispatch_pkg::FU_OP_MINUS;
      isa_pkg::OP_ORR:                   ctl.fu_op = dispatch_pkg::FU_OP_OR;
      isa_pkg::OP_EOR:                   ctl.fu_op = dispatch_pkg::FU_OP_EOR;
      isa_pkg::OP_ANDS:                  ctl.fu_op = dispatch_pkg::FU_OP_AND;
      isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK: ctl.fu_op = dispatch_pkg::FU_OP_MOV;
      isa_pkg::OP_LDUR:                  ctl.fu_op = dispatch_pkg::FU_OP_LDUR;
      isa_pkg::OP_STUR:                  ctl.fu_op = dispatch_pkg::FU_OP_STUR;
      isa_pkg::OP_B_COND:                ctl.fu_op = dispatch_pkg::FU_OP_B_COND;
      // Branches, NOP, HLT and ERR just pass operand A
      default:                           ctl.fu_op = dispatch_pkg::FU_OP_PASS_A;
    endcase

    ctl.set_nzcv = opcode inside {isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ANDS};

    ctl.use_imm = opcode inside {isa_pkg::OP_LDUR, isa_pkg::OP_STUR,
                                 isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK,
                                 isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                                 isa_pkg::OP_B, isa_pkg::OP_B_COND,
                                 isa_pkg::OP_BL};

    ctl.uses_nzcv = (opcode == isa_pkg::OP_B_COND);

    // Register-indirect targets are never predicted
    ctl.mispredict = opcode inside {isa_pkg::OP_BR, isa_pkg::OP_RET};
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      done <= 1'b0;
    end else begin
      done <= valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (valid) begin
      decoded.pc       <= pc;
      decoded.operands <= operands;
      decoded.ctl      <= ctl;
    end
  end

endmodule

`default_nettype wire

// File: hdl/dispatch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_top (
  input  logic                     in_clk,
  input  logic                     in_rst,
  input  logic                     in_fetch_done,
  input  dispatch_pkg::fetch_pkt_t fetch,
  output logic                     done,
  output dispatch_pkg::decoded_t   decoded
);

  logic                    valid;
  isa_pkg::insn_t          insn;
  isa_pkg::gpr_t           pc;
  isa_pkg::opcode_t        opcode;
  dispatch_pkg::operands_t operands;

  fetch_stage u_fetch (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .in_fetch_done (in_fetch_done),
    .fetch         (fetch),
    .valid         (valid),
    .insn          (insn),
    .pc            (pc),
    .opcode        (opcode)
  );

  operand_extract u_extract (
    .insn     (insn),
    .opcode   (opcode),
    .operands (operands)
  );

  dispatch_stage u_dispatch (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .valid    (valid),
    .opcode   (opcode),
    .pc       (pc),
    .operands (operands),
    .done     (done),
    .decoded  (decoded)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_consts.svh"

module fetch_stage (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    in_fetch_done,
  input  dispatch_pkg::fetch_pkt_t fetch,
  output logic                    valid,
  output isa_pkg::insn_t          insn,
  output isa_pkg::gpr_t           pc,
  output isa_pkg::opcode_t        opcode
);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      valid <= 1'b0;
    end else begin
      valid <= in_fetch_done;
    end
  end

  // Word and PC hold until the next fetch strobe
  always_ff @(posedge in_clk) begin
    if (in_fetch_done) begin
      insn <= fetch.insn;
      pc   <= fetch.pc;
    end
  end

  // First matching pattern wins
  always_comb begin
    casez (insn)
      // Unscaled 64-bit store and load
      32'b1111_1000_000?_????_????_00??_????_????: opcode = isa_pkg::OP_STUR;
      32'b1111_1000_010?_????_????_00??_????_????: opcode = isa_pkg::OP_LDUR;
      // Wide moves
      32'b1101_0010_1???_????_????_????_????_????: opcode = isa_pkg::OP_MOVZ;
      32'b1111_0010_1???_????_????_????_????_????: opcode = isa_pkg::OP_MOVK;
      // Arithmetic, immediate and shifted register forms
      32'b1001_0001_0???_????_????_????_????_????: opcode = isa_pkg::OP_ADD;
      32'b1010_1011_000?_????_????_????_????_????: opcode = isa_pkg::OP_ADDS;
      32'b1101_0001_0???_????_????_????_????_????: opcode = isa_pkg::OP_SUB;
      32'b1110_1011_000?_????_????_????_????_????: opcode = isa_pkg::OP_SUBS;
      // Logic on registers
      32'b1010_1010_000?_????_????_????_????_????: opcode = isa_pkg::OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: opcode = isa_pkg::OP_EOR;
      32'b1110_1010_000?_????_????_????_????_????: opcode = isa_pkg::OP_ANDS;
      // Immediate branches
      32'b0001_01??_????_????_????_????_????_????: opcode = isa_pkg::OP_B;
      32'b0101_0100_????_????_????_????_???0_????: opcode = isa_pkg::OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: opcode = isa_pkg::OP_BL;
      // Register branches and compare-and-branch
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = isa_pkg::OP_BR;
      32'b1011_0101_????_????_????_????_????_????: opcode = isa_pkg::OP_CBNZ;
      32'b1011_0100_????_????_????_????_????_????: opcode = isa_pkg::OP_CBZ;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = isa_pkg::OP_RET;
      // Hint and halt
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = isa_pkg::OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: opcode = isa_pkg::OP_HLT;
      default:                                     opcode = isa_pkg::OP_ERR;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "dispatch_consts.svh"

package isa_pkg;

  typedef logic [`INSN_BITS-1:0] insn_t;
  typedef logic [`GPR_IDX_BITS-1:0] gpr_idx_t;
  typedef logic [`GPR_BITS-1:0] gpr_t;
  typedef logic [`IMM_BITS-1:0] imm_t;

  // Decoded instruction class, OP_ERR for anything not recognized
  typedef enum logic [4:0] {
    OP_LDUR,
    OP_STUR,
    OP_ADD,
    OP_SUB,
    OP_ADDS,
    OP_SUBS,
    OP_ORR,
    OP_EOR,
    OP_ANDS,
    OP_MOVZ,
    OP_MOVK,
    OP_B,
    OP_B_COND,
    OP_BL,
    OP_CBZ,
    OP_CBNZ,
    OP_BR,
    OP_RET,
    OP_NOP,
    OP_HLT,
    OP_ERR
  } opcode_t;

  // Arm condition codes in encoding order
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

endpackage

`default_nettype wire

// File: hdl/operand_extract.sv
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_consts.svh"

module operand_extract (
  input  isa_pkg::insn_t          insn,
  input  isa_pkg::opcode_t        opcode,
  output dispatch_pkg::operands_t operands
);

  localparam isa_pkg::gpr_idx_t ZERO_IDX = isa_pkg::gpr_idx_t'(`ZERO_REG);
  localparam isa_pkg::gpr_idx_t LINK_IDX = isa_pkg::gpr_idx_t'(`LINK_REG);

  always_comb begin
    // Destination
    case (opcode)
      isa_pkg::OP_B, isa_pkg::OP_BR, isa_pkg::OP_B_COND, isa_pkg::OP_CBZ,
      isa_pkg::OP_CBNZ, isa_pkg::OP_RET, isa_pkg::OP_NOP, isa_pkg::OP_HLT,
      isa_pkg::OP_ERR: begin
        operands.dst        = ZERO_IDX;
        operands.dst_status = dispatch_pkg::REG_IS_UNUSED;
      end
      isa_pkg::OP_STUR: begin
        operands.dst        = ZERO_IDX;
        operands.dst_status = dispatch_pkg::REG_IS_STUR;
      end
      isa_pkg::OP_BL: begin
        operands.dst        = LINK_IDX;
        operands.dst_status = dispatch_pkg::REG_IS_USED;
      end
      default: begin
        operands.dst        = insn[4:0];
        operands.dst_status = dispatch_pkg::REG_IS_USED;
      end
    endcase

    // First source, compare-and-branch tests the Rt field
    case (opcode)
      isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK, isa_pkg::OP_B, isa_pkg::OP_B_COND,
      isa_pkg::OP_BL, isa_pkg::OP_NOP, isa_pkg::OP_HLT: begin
        operands.src1        = ZERO_IDX;
        operands.src1_status = dispatch_pkg::REG_IS_UNUSED;
      end
      isa_pkg::OP_CBZ, isa_pkg::OP_CBNZ: begin
        operands.src1        = insn[4:0];
        operands.src1_status = dispatch_pkg::REG_IS_USED;
      end
      default: begin
        operands.src1        = insn[9:5];
        operands.src1_status = dispatch_pkg::REG_IS_USED;
      end
    endcase

    // Second source, store data comes from Rt
    case (opcode)
      isa_pkg::OP_STUR: begin
        operands.src2        = insn[4:0];
        operands.src2_status = dispatch_pkg::REG_IS_USED;
      end
      isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ORR, isa_pkg::OP_EOR,
      isa_pkg::OP_ANDS: begin
        operands.src2        = insn[20:16];
        operands.src2_status = dispatch_pkg::REG_IS_USED;
      end
      default: begin
        operands.src2        = ZERO_IDX;
        operands.src2_status = dispatch_pkg::REG_IS_UNUSED;
      end
    endcase

    // Immediates are zero-extended, branch offsets scaled to bytes
    case (opcode)
      isa_pkg::OP_LDUR, isa_pkg::OP_STUR: operands.imm = isa_pkg::imm_t'(insn[20:12]);
      isa_pkg::OP_ADD, isa_pkg::OP_SUB:   operands.imm = isa_pkg::imm_t'(insn[21:10]);
      isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK: operands.imm = isa_pkg::imm_t'(insn[20:5]);
      isa_pkg::OP_B, isa_pkg::OP_BL:      operands.imm = isa_pkg::imm_t'({insn[25:0], 2'b00});
      isa_pkg::OP_B_COND, isa_pkg::OP_CBZ, isa_pkg::OP_CBNZ:
        operands.imm = isa_pkg::imm_t'({insn[23:5], 2'b00});
      default: operands.imm = '0;
    endcase

    operands.imm_signed = !(opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                                           isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK});

    if (opcode == isa_pkg::OP_B_COND) begin
      operands.cond = isa_pkg::cond_t'(insn[3:0]);
    end else begin
      operands.cond = isa_pkg::COND_EQ;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_dispatch_ref.svh
  // Fixed bits of each kept encoding as {mask, value}, indexed in opcode order
  function automatic logic [63:0] pattern(int k);
    case (k)
      0:       return {32'hFFE0_0C00, 32'hF840_0000};  // LDUR
      1:       return {32'hFFE0_0C00, 32'hF800_0000};  // STUR
      2:       return {32'hFF80_0000, 32'h9100_0000};  // ADD
      3:       return {32'hFF80_0000, 32'hD100_0000};  // SUB
      4:       return {32'hFFE0_0000, 32'hAB00_0000};  // ADDS
      5:       return {32'hFFE0_0000, 32'hEB00_0000};  // SUBS
      6:       return {32'hFFE0_0000, 32'hAA00_0000};  // ORR
      7:       return {32'hFFE0_0000, 32'hCA00_0000};  // EOR
      8:       return {32'hFFE0_0000, 32'hEA00_0000};  // ANDS
      9:       return {32'hFF80_0000, 32'hD280_0000};  // MOVZ
      10:      return {32'hFF80_0000, 32'hF280_0000};  // MOVK
      11:      return {32'hFC00_0000, 32'h1400_0000};  // B
      12:      return {32'hFF00_0010, 32'h5400_0000};  // B.cond
      13:      return {32'hFC00_0000, 32'h9400_0000};  // BL
      14:      return {32'hFF00_0000, 32'hB400_0000};  // CBZ
      15:      return {32'hFF00_0000, 32'hB500_0000};  // CBNZ
      16:      return {32'hFFFF_FC1F, 32'hD61F_0000};  // BR
      17:      return {32'hFFFF_FC1F, 32'hD65F_0000};  // RET
      18:      return {32'hFFFF_FFFF, 32'hD503_201F};  // NOP
      default: return {32'hFFE0_001F, 32'hD440_0000};  // HLT
    endcase
  endfunction

  // Expected bundle for one fetched word and its PC
  function automatic dispatch_pkg::decoded_t ref_decode(isa_pkg::insn_t w, isa_pkg::gpr_t pc);
    dispatch_pkg::decoded_t d;
    isa_pkg::opcode_t op;
    logic [63:0] p;
    logic no_dst;
    logic no_src1;
    logic reg_src2;
    isa_pkg::gpr_idx_t zero_idx;
    zero_idx = isa_pkg::gpr_idx_t'(`ZERO_REG);
    // Walk down so the lowest matching index wins
    op = isa_pkg::OP_ERR;
    for (int k = 19; k >= 0; k--) begin
      p = pattern(k);
      if ((w & p[63:32]) == p[31:0]) begin
        op = isa_pkg::opcode_t'(k);
      end
    end
    no_dst = op inside {isa_pkg::OP_B, isa_pkg::OP_BR, isa_pkg::OP_B_COND, isa_pkg::OP_CBZ,
                        isa_pkg::OP_CBNZ, isa_pkg::OP_RET, isa_pkg::OP_NOP, isa_pkg::OP_HLT,
                        isa_pkg::OP_ERR};
    no_src1 = op inside {isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK, isa_pkg::OP_B, isa_pkg::OP_B_COND,
                         isa_pkg::OP_BL, isa_pkg::OP_NOP, isa_pkg::OP_HLT};
    reg_src2 = op inside {isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ORR, isa_pkg::OP_EOR,
                          isa_pkg::OP_ANDS};

    d.pc = pc;
    d.operands.dst = (no_dst || op == isa_pkg::OP_STUR) ? zero_idx : w[4:0];
    d.operands.dst_status = no_dst ? dispatch_pkg::REG_IS_UNUSED : dispatch_pkg::REG_IS_USED;
    if (op == isa_pkg::OP_STUR) begin
      d.operands.dst_status = dispatch_pkg::REG_IS_STUR;
    end
    if (op == isa_pkg::OP_BL) begin
      d.operands.dst = isa_pkg::gpr_idx_t'(`LINK_REG);
    end
    d.operands.src1 = no_src1 ? zero_idx : w[9:5];
    if (op == isa_pkg::OP_CBZ || op == isa_pkg::OP_CBNZ) begin
      d.operands.src1 = w[4:0];
    end
    d.operands.src1_status = no_src1 ? dispatch_pkg::REG_IS_UNUSED : dispatch_pkg::REG_IS_USED;
    d.operands.src2 = reg_src2 ? w[20:16] : zero_idx;
    d.operands.src2_status = reg_src2 ? dispatch_pkg::REG_IS_USED
                                      : dispatch_pkg::REG_IS_UNUSED;
    // Store data register
    if (op == isa_pkg::OP_STUR) begin
      d.operands.src2 = w[4:0];
      d.operands.src2_status = dispatch_pkg::REG_IS_USED;
    end

    case (op)
      isa_pkg::OP_LDUR, isa_pkg::OP_STUR: d.operands.imm = isa_pkg::imm_t'(w[20:12]);
      isa_pkg::OP_ADD, isa_pkg::OP_SUB:   d.operands.imm = isa_pkg::imm_t'(w[21:10]);
      isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK: d.operands.imm = isa_pkg::imm_t'(w[20:5]);
      isa_pkg::OP_B, isa_pkg::OP_BL:      d.operands.imm = isa_pkg::imm_t'({w[25:0], 2'b00});
      isa_pkg::OP_B_COND, isa_pkg::OP_CBZ, isa_pkg::OP_CBNZ:
        d.operands.imm = isa_pkg::imm_t'({w[23:5], 2'b00});
      default: d.operands.imm = '0;
    endcase
    d.operands.imm_signed = !(op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                                         isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK});
    d.operands.cond = (op == isa_pkg::OP_B_COND) ? isa_pkg::cond_t'(w[3:0]) : isa_pkg::COND_EQ;

    d.ctl.fu_id = (op == isa_pkg::OP_LDUR || op == isa_pkg::OP_STUR) ? dispatch_pkg::FU_LS
                                                                     : dispatch_pkg::FU_ALU;
    case (op)
      isa_pkg::OP_ADD, isa_pkg::OP_ADDS:  d.ctl.fu_op = dispatch_pkg::FU_OP_PLUS;
      isa_pkg::OP_SUB, isa_pkg::OP_SUBS:  d.ctl.fu_op = dispatch_pkg::FU_OP_MINUS;
      isa_pkg::OP_ORR:                    d.ctl.fu_op = dispatch_pkg::FU_OP_OR;
      isa_pkg::OP_EOR:                    d.ctl.fu_op = dispatch_pkg::FU_OP_EOR;
      isa_pkg::OP_ANDS:                   d.ctl.fu_op = dispatch_pkg::FU_OP_AND;
      isa_pkg::OP_MOVZ, isa_pkg::OP_MOVK: d.ctl.fu_op = dispatch_pkg::FU_OP_MOV;
      isa_pkg::OP_LDUR:                   d.ctl.fu_op = dispatch_pkg::FU_OP_LDUR;
      isa_pkg::OP_STUR:                   d.ctl.fu_op = dispatch_pkg::FU_OP_STUR;
      isa_pkg::OP_B_COND:                 d.ctl.fu_op = dispatch_pkg::FU_OP_B_COND;
      default:                            d.ctl.fu_op = dispatch_pkg::FU_OP_PASS_A;
    endcase
    d.ctl.set_nzcv = op inside {isa_pkg::OP_ADDS, isa_pkg::OP_SUBS, isa_pkg::OP_ANDS};
    d.ctl.use_imm = op inside {isa_pkg::OP_LDUR, isa_pkg::OP_STUR, isa_pkg::OP_MOVZ,
                               isa_pkg::OP_MOVK, isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                               isa_pkg::OP_B, isa_pkg::OP_B_COND, isa_pkg::OP_BL};
    d.ctl.uses_nzcv = (op == isa_pkg::OP_B_COND);
    d.ctl.mispredict = op inside {isa_pkg::OP_BR, isa_pkg::OP_RET};
    return d;
  endfunction

// File: testbench/tb_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

`include "dispatch_consts.svh"

module tb_dispatch;

  logic                     in_clk;
  logic                     in_rst;
  logic                     in_fetch_done;
  dispatch_pkg::fetch_pkt_t fetch;
  logic                     done;
  dispatch_pkg::decoded_t   decoded;

  // Expected bundles and the edge at which each done is due
  dispatch_pkg::decoded_t exp_q[$];
  int                     due_q[$];
  dispatch_pkg::decoded_t expected;
  int                     due;
  int                     edge_count = 0;
  integer                 seed = 32'h9c87dcc2;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     wait_cycles;
  int                     burst;

  `include "tb_dispatch_ref.svh"

  dispatch_top u_dut (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .in_fetch_done (in_fetch_done),
    .fetch         (fetch),
    .done          (done),
    .decoded       (decoded)
  );

  always #4 in_clk = ~in_clk;

  always @(posedge in_clk) begin
    edge_count <= edge_count + 1;
  end

  // Template for opcode k with its free bits randomized
  function automatic isa_pkg::insn_t template_word(int k);
    logic [63:0] p;
    p = pattern(k);
    return ($random(seed) & ~p[63:32]) | p[31:0];
  endfunction

  task automatic send_word(isa_pkg::insn_t w);
    isa_pkg::gpr_t pc;
    @(posedge in_clk);
    pc = {$random(seed), $random(seed)};
    in_fetch_done <= 1'b1;
    fetch.insn <= w;
    fetch.pc <= pc;
    exp_q.push_back(ref_decode(w, pc));
    // Sampled at the next edge, done follows one edge after that
    due_q.push_back(edge_count + 3);
  endtask

  // Payload toggles while idle and must be ignored
  task automatic idle_cycle();
    @(posedge in_clk);
    in_fetch_done <= 1'b0;
    fetch <= {$random(seed), $random(seed), $random(seed)};
  endtask

  task automatic check_field(string name, logic [63:0] exp_v, logic [63:0] act_v);
    if (act_v !== exp_v) begin
      value_errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_bundle(dispatch_pkg::decoded_t e);
    check_field("decoded.pc", e.pc, decoded.pc);
    check_field("decoded.operands.src1", 64'(e.operands.src1), 64'(decoded.operands.src1));
    check_field("decoded.operands.src1_status", 64'(e.operands.src1_status),
                64'(decoded.operands.src1_status));
    check_field("decoded.operands.src2", 64'(e.operands.src2), 64'(decoded.operands.src2));
    check_field("decoded.operands.src2_status", 64'(e.operands.src2_status),
                64'(decoded.operands.src2_status));
    check_field("decoded.operands.dst", 64'(e.operands.dst), 64'(decoded.operands.dst));
    check_field("decoded.operands.dst_status", 64'(e.operands.dst_status),
                64'(decoded.operands.dst_status));
    check_field("decoded.operands.imm", e.operands.imm, decoded.operands.imm);
    check_field("decoded.operands.imm_signed", 64'(e.operands.imm_signed),
                64'(decoded.operands.imm_signed));
    check_field("decoded.operands.cond", 64'(e.operands.cond), 64'(decoded.operands.cond));
    check_field("decoded.ctl.fu_id", 64'(e.ctl.fu_id), 64'(decoded.ctl.fu_id));
    check_field("decoded.ctl.fu_op", 64'(e.ctl.fu_op), 64'(decoded.ctl.fu_op));
    check_field("decoded.ctl.set_nzcv", 64'(e.ctl.set_nzcv), 64'(decoded.ctl.set_nzcv));
    check_field("decoded.ctl.use_imm", 64'(e.ctl.use_imm), 64'(decoded.ctl.use_imm));
    check_field("decoded.ctl.uses_nzcv", 64'(e.ctl.uses_nzcv), 64'(decoded.ctl.uses_nzcv));
    check_field("decoded.ctl.mispredict", 64'(e.ctl.mispredict), 64'(decoded.ctl.mispredict));
  endtask

  // Match each done strobe against the oldest expected bundle
  always @(negedge in_clk) begin
    if (edge_count > 0 && done === 1'b1) begin
      if (exp_q.size() == 0) begin
        protocol_errors++;
        $display("done strobe at edge %0d with no word outstanding", edge_count);
      end else begin
        expected = exp_q.pop_front();
        due = due_q.pop_front();
        if (due != edge_count) begin
          protocol_errors++;
          $display("done at edge %0d but the word was due at edge %0d", edge_count, due);
        end
        compare_bundle(expected);
      end
    end else if (edge_count > 0 && done !== 1'b0) begin
      protocol_errors++;
      $display("done is unknown at edge %0d", edge_count);
    end else if (due_q.size() > 0 && due_q[0] == edge_count) begin
      protocol_errors++;
      $display("no done for the word due at edge %0d", edge_count);
      expected = exp_q.pop_front();
      due = due_q.pop_front();
    end
  end

  initial begin
    in_clk = 1'b0;
    in_rst = 1'b1;
    in_fetch_done = 1'b0;
    fetch = '0;
    repeat (2) @(posedge in_clk);
    in_rst <= 1'b0;
    // Quiet period, done must stay low
    repeat (4) idle_cycle();
    // Every template once, back to back, then two unmatched words
    for (int k = 0; k < 20; k++) begin
      send_word(template_word(k));
    end
    send_word(32'h0000_0000);
    send_word(32'hFFFF_FFFF);
    // Random bursts separated by random gaps
    for (int n = 0; n < 60; n++) begin
      burst = 1 + $unsigned($random(seed)) % 8;
      repeat (burst) begin
        if (($random(seed) & 3) == 0) begin
          send_word($random(seed));
        end else begin
          send_word(template_word($unsigned($random(seed)) % 20));
        end
      end
      repeat ($unsigned($random(seed)) % 6) idle_cycle();
    end
    idle_cycle();

    wait_cycles = 0;
    while (exp_q.size() > 0 && wait_cycles < 10) begin
      @(posedge in_clk);
      wait_cycles++;
    end
    if (exp_q.size() > 0) begin
      protocol_errors++;
      $display("timed out with %0d words still waiting for done", exp_q.size());
    end
    // Extra strobes would show up here
    repeat (4) idle_cycle();
    @(posedge in_clk);

    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
